/* hw/smem_pkg.sv */
package smem_pkg;

    // Bytes per word
    localparam int WORD_SIZE = 4;
    localparam int WORD_WIDTH = WORD_SIZE * 8;

    // Word address, bank select in the low bits
    localparam int ADDR_WIDTH = 8;

    localparam int TAG_WIDTH = 4;

    // Sizes the issuing-port index
    localparam int MAX_REQS = 8;
    localparam int REQ_IDX_WIDTH = $clog2(MAX_REQS);

    typedef logic [WORD_WIDTH-1:0]    word_t;
    typedef logic [WORD_SIZE-1:0]     byteen_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [TAG_WIDTH-1:0]     tag_t;
    typedef logic [REQ_IDX_WIDTH-1:0] req_idx_t;

    // rw is 1 for a write
    typedef struct packed {
        logic    rw;
        addr_t   addr;
        byteen_t byteen;
        word_t   data;
        tag_t    tag;
    } core_req_t;

    typedef struct packed {
        logic     rw;
        addr_t    addr;
        byteen_t  byteen;
        word_t    data;
        tag_t     tag;
        req_idx_t idx;
    } bank_req_t;

    // Reads only, writes return nothing
    typedef struct packed {
        word_t    data;
        tag_t     tag;
        req_idx_t idx;
    } bank_rsp_t;

    typedef struct packed {
        word_t data;
        tag_t  tag;
    } core_rsp_t;

endpackage

/* hw/smem_req_dispatch.sv */
`timescale 1ns/1ps

module smem_req_dispatch #(
    parameter int NUM_REQS  = 4,
    parameter int NUM_BANKS = 2
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [NUM_REQS-1:0]                 req_valid,
    input  smem_pkg::core_req_t [NUM_REQS-1:0]  req,
    output logic [NUM_REQS-1:0]                 req_ready,

    output logic [NUM_BANKS-1:0]                bank_req_valid,
    output smem_pkg::bank_req_t [NUM_BANKS-1:0] bank_req,
    input  logic [NUM_BANKS-1:0]                bank_req_ready
);
    import smem_pkg::*;

    logic [NUM_BANKS-1:0][NUM_REQS-1:0] bank_cand;
    logic [NUM_BANKS-1:0][NUM_REQS-1:0] grant;
    req_idx_t [NUM_BANKS-1:0]           winner;

    // Per-bank round-robin pointer to the first port looked at
    req_idx_t [NUM_BANKS-1:0]           ptr;

    // Bank is the word address modulo the bank count
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                bank_cand[b][i] = req_valid[i] && ((int'(req[i].addr) % NUM_BANKS) == b);
            end
        end
    end

    // Rotating priority starting at ptr
    always_comb begin
        int   idx;
        logic found;
        grant = '0;
        winner = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            found = 1'b0;
            for (int k = 0; k < NUM_REQS; k++) begin
                idx = (int'(ptr[b]) + k) % NUM_REQS;
                if (!found && bank_cand[b][idx]) begin
                    found = 1'b1;
                    grant[b][idx] = 1'b1;
                    winner[b] = req_idx_t'(idx);
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_valid[b] = |grant[b];
            bank_req[b] = '{
                rw:     req[winner[b]].rw,
                addr:   req[winner[b]].addr,
                byteen: req[winner[b]].byteen,
                data:   req[winner[b]].data,
                tag:    req[winner[b]].tag,
                idx:    winner[b]
            };
        end
    end

    // Only the winner at a ready bank sees ready
    always_comb begin
        req_ready = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                if (grant[b][i] && bank_req_ready[b]) begin
                    req_ready[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_req_valid[b] && bank_req_ready[b]) begin
                    ptr[b] <= req_idx_t'((int'(winner[b]) + 1) % NUM_REQS);
                end
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_grant_chk
        // Ports that see ready at a bank match that bank's handshake
        assert property (@(posedge clk) disable iff (reset)
            $onehot0(bank_cand[b] & req_ready)
            && ((bank_req_valid[b] && bank_req_ready[b]) == (|(bank_cand[b] & req_ready))))
            else $error("bank %0d accepted from several ports or lost a handshake", b);
    end

endmodule

/* hw/smem_bank.sv */
`timescale 1ns/1ps

module smem_bank #(
    parameter int NUM_BANKS = 2
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                bank_req_valid,
    input  smem_pkg::bank_req_t bank_req,
    output logic                bank_req_ready,

    output logic                bank_rsp_valid,
    output smem_pkg::bank_rsp_t bank_rsp,
    input  logic                bank_rsp_ready
);
    import smem_pkg::*;

    localparam int BANK_SEL_BITS   = $clog2(NUM_BANKS);
    localparam int BANK_ADDR_WIDTH = ADDR_WIDTH - BANK_SEL_BITS;
    localparam int BANK_DEPTH      = (2 ** ADDR_WIDTH) / NUM_BANKS;

    word_t mem [BANK_DEPTH];

    logic                       in_valid;
    bank_req_t                  in_req;
    logic [BANK_ADDR_WIDTH-1:0] ram_addr;
    logic                       rsp_stall;
    logic                       in_advance;

    // Low address bits already picked the bank
    assign ram_addr = BANK_ADDR_WIDTH'(in_req.addr >> BANK_SEL_BITS);

    assign rsp_stall = bank_rsp_valid && !bank_rsp_ready;

    // Writes never wait on the response register
    assign in_advance = in_valid && (in_req.rw || !rsp_stall);

    assign bank_req_ready = !in_valid || in_advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid <= 1'b0;
        end else if (bank_req_ready) begin
            in_valid <= bank_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (bank_req_valid && bank_req_ready) begin
            in_req <= bank_req;
        end
    end

    // Byte-lane write enables
    always_ff @(posedge clk) begin
        if (in_advance && in_req.rw) begin
            for (int l = 0; l < WORD_SIZE; l++) begin
                if (in_req.byteen[l]) begin
                    mem[ram_addr][l*8 +: 8] <= in_req.data[l*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_rsp_valid <= 1'b0;
        end else if (in_advance && !in_req.rw) begin
            bank_rsp_valid <= 1'b1;
        end else if (bank_rsp_ready) begin
            bank_rsp_valid <= 1'b0;
        end
    end

    // Read data lands with its tag and port
    always_ff @(posedge clk) begin
        if (in_advance && !in_req.rw) begin
            bank_rsp <= '{
                data: mem[ram_addr],
                tag:  in_req.tag,
                idx:  in_req.idx
            };
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        bank_rsp_valid && !bank_rsp_ready |=> bank_rsp_valid && $stable(bank_rsp))
        else $error("bank response changed while stalled");

endmodule

/* hw/smem_rsp_merge.sv */
`timescale 1ns/1ps

module smem_rsp_merge #(
    parameter int NUM_REQS  = 4,
    parameter int NUM_BANKS = 2
) (
    input  logic                                clk,

    input  logic [NUM_BANKS-1:0]                bank_rsp_valid,
    input  smem_pkg::bank_rsp_t [NUM_BANKS-1:0] bank_rsp,
    output logic [NUM_BANKS-1:0]                bank_rsp_ready,

    output logic [NUM_REQS-1:0]                 rsp_valid,
    output smem_pkg::core_rsp_t [NUM_REQS-1:0]  rsp,
    input  logic [NUM_REQS-1:0]                 rsp_ready
);
    import smem_pkg::*;

    logic [NUM_REQS-1:0][NUM_BANKS-1:0] port_hs;

    // Lower bank wins when two banks answer one port
    always_comb begin
        int port;
        bank_rsp_ready = '0;
        rsp_valid = '0;
        rsp = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            port = int'(bank_rsp[b].idx);
            if (bank_rsp_valid[b] && port < NUM_REQS && !rsp_valid[port]) begin
                rsp_valid[port] = 1'b1;
                rsp[port] = '{data: bank_rsp[b].data, tag: bank_rsp[b].tag};
                bank_rsp_ready[b] = rsp_ready[port];
            end
        end
    end

    // Completed bank handshakes per port
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                port_hs[i][b] = bank_rsp_valid[b] && bank_rsp_ready[b]
                              && (int'(bank_rsp[b].idx) == i);
            end
        end
    end

    // A port handshake consumes exactly one bank response
    for (genvar i = 0; i < NUM_REQS; i++) begin : g_port_chk
        assert property (@(posedge clk)
            $onehot0(port_hs[i]) && ((|port_hs[i]) == (rsp_valid[i] && rsp_ready[i])))
            else $error("port %0d handshake does not match one bank response", i);
    end

endmodule

/* hw/smem_top.sv */
`timescale 1ns/1ps

module smem_top #(
    parameter int NUM_REQS  = 4,
    parameter int NUM_BANKS = 2
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [NUM_REQS-1:0]                 req_valid,
    input  smem_pkg::core_req_t [NUM_REQS-1:0]  req,
    output logic [NUM_REQS-1:0]                 req_ready,

    output logic [NUM_REQS-1:0]                 rsp_valid,
    output smem_pkg::core_rsp_t [NUM_REQS-1:0]  rsp,
    input  logic [NUM_REQS-1:0]                 rsp_ready
);
    import smem_pkg::*;

    logic [NUM_BANKS-1:0]      bank_req_valid;
    bank_req_t [NUM_BANKS-1:0] bank_req;
    logic [NUM_BANKS-1:0]      bank_req_ready;

    logic [NUM_BANKS-1:0]      bank_rsp_valid;
    bank_rsp_t [NUM_BANKS-1:0] bank_rsp;
    logic [NUM_BANKS-1:0]      bank_rsp_ready;

    smem_req_dispatch #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) req_dispatch_i (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready)
    );

    // Banks run independently
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        smem_bank #(
            .NUM_BANKS (NUM_BANKS)
        ) bank_i (
            .clk            (clk),
            .reset          (reset),
            .bank_req_valid (bank_req_valid[b]),
            .bank_req       (bank_req[b]),
            .bank_req_ready (bank_req_ready[b]),
            .bank_rsp_valid (bank_rsp_valid[b]),
            .bank_rsp       (bank_rsp[b]),
            .bank_rsp_ready (bank_rsp_ready[b])
        );
    end

    smem_rsp_merge #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) rsp_merge_i (
        .clk            (clk),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready)
    );

endmodule

/* testbench/smem_tb.sv */
`timescale 1ns/1ps

module smem_tb;
    import smem_pkg::*;

    localparam int    NUM_REQS    = 4;
    localparam int    NUM_BANKS   = 2;
    localparam int    NUM_TAGS    = 2 ** TAG_WIDTH;
    localparam int    MAX_ENTRIES = 64;
    localparam string GOLDEN_FILE = "testbench/smem_golden.txt";

    logic                     clk;
    logic                     reset;
    logic [NUM_REQS-1:0]      req_valid;
    core_req_t [NUM_REQS-1:0] req;
    logic [NUM_REQS-1:0]      req_ready;
    logic [NUM_REQS-1:0]      rsp_valid;
    core_rsp_t [NUM_REQS-1:0] rsp;
    logic [NUM_REQS-1:0]      rsp_ready;

    // Golden entries in file order
    string   ent_name [MAX_ENTRIES];
    int      ent_step [MAX_ENTRIES];
    logic    ent_rw   [MAX_ENTRIES];
    addr_t   ent_addr [MAX_ENTRIES];
    byteen_t ent_be   [MAX_ENTRIES];
    word_t   ent_data [MAX_ENTRIES];
    tag_t    ent_tag  [MAX_ENTRIES];
    word_t   ent_exp  [MAX_ENTRIES];
    int      num_entries;
    bit      load_ok;

    int      port_q [NUM_REQS][$];
    string   test_names [$];
    int      test_first [$];
    int      test_last [$];

    // Outstanding reads by port and tag
    bit      pend     [NUM_REQS][NUM_TAGS];
    int      pend_ent [NUM_REQS][NUM_TAGS];
    int      pend_seq [NUM_REQS][NUM_TAGS];
    int      issued   [NUM_REQS][NUM_BANKS];
    int      returned [NUM_REQS][NUM_BANKS];
    int      outstanding;

    int      cur_step;
    bit      bp_mode;
    integer  seed = 32'h0769_2aff;
    int      test_errs;
    int      pass_count;
    int      fail_count;
    int      cycle_count = 0;
    int      timeout_limit;
    bit      loaded;

    smem_top #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) smem_top_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          code;
        int          step;
        int          port;
        string       tok;
        string       op;
        string       rest;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] data;
        logic [31:0] tag;
        logic [31:0] expv;
        num_entries = 0;
        load_ok = 1'b1;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open golden file %s", GOLDEN_FILE);
            load_ok = 1'b0;
            return;
        end
        while (!$feof(fd) && num_entries < MAX_ENTRIES) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) break;
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(rest, fd));
            end else begin
                code = $fscanf(fd, "%d %d %s %h %h %h %h %h",
                               step, port, op, addr, be, data, tag, expv);
                if (code != 8 || port < 0 || port >= NUM_REQS) begin
                    $display("Golden entry for test %s could not be parsed", tok);
                    load_ok = 1'b0;
                    break;
                end
                ent_name[num_entries] = tok;
                ent_step[num_entries] = step;
                ent_rw[num_entries]   = (op == "W");
                ent_addr[num_entries] = addr_t'(addr);
                ent_be[num_entries]   = byteen_t'(be);
                ent_data[num_entries] = data;
                ent_tag[num_entries]  = tag_t'(tag);
                ent_exp[num_entries]  = expv;
                port_q[port].push_back(num_entries);
                if (test_names.size() == 0 || test_names[test_names.size()-1] != tok) begin
                    test_names.push_back(tok);
                    test_first.push_back(step);
                    test_last.push_back(step);
                end else begin
                    test_last[test_last.size()-1] = step;
                end
                num_entries++;
            end
        end
        $fclose(fd);
    endtask

    // Read handshake, remember what the response must carry
    task automatic accept_request(input int p);
        int e;
        int t;
        int b;
        e = port_q[p][0];
        if (!ent_rw[e]) begin
            t = int'(ent_tag[e]);
            b = int'(ent_addr[e]) % NUM_BANKS;
            if (pend[p][t]) begin
                $display("Port %0d reused tag %h while a read with it was outstanding", p, t);
                test_errs++;
            end
            pend[p][t] = 1'b1;
            pend_ent[p][t] = e;
            pend_seq[p][t] = issued[p][b];
            issued[p][b]++;
            outstanding++;
        end
        void'(port_q[p].pop_front());
    endtask

    task automatic take_response(input int p);
        int t;
        int e;
        int b;
        t = int'(rsp[p].tag);
        if (!pend[p][t]) begin
            $display("Port %0d got a response with tag %h that no read was waiting for", p, t);
            test_errs++;
        end else begin
            e = pend_ent[p][t];
            b = int'(ent_addr[e]) % NUM_BANKS;
            check_value(ent_name[e], ent_exp[e], rsp[p].data);
            // Same bank answers a port in issue order
            check_value({ent_name[e], "_order"}, returned[p][b], pend_seq[p][t]);
            returned[p][b]++;
            pend[p][t] = 1'b0;
            outstanding--;
        end
    endtask

    always @(posedge clk) begin : drive_ports
        int e;
        bit busy;
        if (reset) begin
            req_valid <= '0;
            rsp_ready <= {NUM_REQS{1'b1}};
        end else begin
            rsp_ready <= bp_mode ? NUM_REQS'($random(seed)) : {NUM_REQS{1'b1}};
            for (int p = 0; p < NUM_REQS; p++) begin
                if (rsp_valid[p] && rsp_ready[p]) begin
                    take_response(p);
                end
                busy = req_valid[p];
                if (req_valid[p] && req_ready[p]) begin
                    accept_request(p);
                    busy = 1'b0;
                end
                if (!busy) begin
                    if (port_q[p].size() > 0 && ent_step[port_q[p][0]] == cur_step) begin
                        e = port_q[p][0];
                        req_valid[p] <= 1'b1;
                        req[p] <= '{
                            rw:     ent_rw[e],
                            addr:   ent_addr[e],
                            byteen: ent_be[e],
                            data:   ent_data[e],
                            tag:    ent_tag[e]
                        };
                    end else begin
                        req_valid[p] <= 1'b0;
                    end
                end
            end
        end
    end

    function automatic bit step_done();
        for (int p = 0; p < NUM_REQS; p++) begin
            if (port_q[p].size() > 0 && ent_step[port_q[p][0]] == cur_step) begin
                return 1'b0;
            end
        end
        return req_valid == '0 && outstanding == 0;
    endfunction

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", name, test_errs);
        end
    endtask

    task automatic run_tests();
        test_errs = 0;
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_value("reset", 32'd0, 32'(rsp_valid));
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("reset", 32'd0, 32'(rsp_valid));
        end
        report_test("reset");

        for (int t = 0; t < test_names.size(); t++) begin
            test_errs = 0;
            bp_mode = (test_names[t] == "backpressure");
            // Steps act as barriers between dependent operations
            for (int s = test_first[t]; s <= test_last[t]; s++) begin
                cur_step = s;
                @(negedge clk);
                while (!step_done()) @(negedge clk);
            end
            bp_mode = 1'b0;
            report_test(test_names[t]);
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        req_valid = '0;
        req = '0;
        rsp_ready = {NUM_REQS{1'b1}};
        cur_step = -1;
        bp_mode = 1'b0;
        outstanding = 0;
        test_errs = 0;
        pass_count = 0;
        fail_count = 0;
        loaded = 1'b0;
        load_golden();
        if (!load_ok || num_entries == 0) begin
            $display("No usable entries were read from %s", GOLDEN_FILE);
            $display("Some tests failed");
            $finish;
        end else begin
            timeout_limit = 40 * num_entries + 200;
            loaded = 1'b1;
            run_tests();
        end
    end

    initial begin
        wait (loaded);
        while (cycle_count < timeout_limit) @(negedge clk);
        $display("Run timed out after %0d cycles with %0d responses still missing",
                 cycle_count, outstanding);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* testbench/smem_golden.txt */
# test step port op addr byteen wdata tag rdata (op is W or R, step and port decimal, rest hex)
# lines with one step number are issued together, a step ends when all its reads returned
write_read    1 0 W 10 f deadbeef 0 00000000
write_read    1 2 W 21 f 12345678 0 00000000
write_read    2 1 R 10 0 00000000 5 deadbeef
write_read    2 3 R 21 0 00000000 9 12345678
byte_en       3 0 W 30 f 11223344 0 00000000
byte_en       3 1 W 41 f a0b0c0d0 0 00000000
byte_en       4 0 W 30 1 aaaaaa55 0 00000000
byte_en       4 0 W 30 4 00cc0000 0 00000000
byte_en       4 1 W 41 a 12345678 0 00000000
byte_en       5 2 R 30 0 00000000 3 11cc3355
byte_en       5 3 R 41 0 00000000 7 12b056d0
bank_conflict 6 0 W 50 f 50505050 0 00000000
bank_conflict 6 1 W 52 f 52525252 0 00000000
bank_conflict 7 0 R 10 0 00000000 1 deadbeef
bank_conflict 7 0 R 30 0 00000000 2 11cc3355
bank_conflict 7 1 R 50 0 00000000 1 50505050
bank_conflict 7 1 R 52 0 00000000 2 52525252
bank_conflict 7 2 R 52 0 00000000 4 52525252
bank_conflict 7 2 R 10 0 00000000 5 deadbeef
bank_conflict 7 3 R 30 0 00000000 6 11cc3355
bank_conflict 7 3 R 50 0 00000000 8 50505050
parallel      8 0 W 60 f 60606060 0 00000000
parallel      8 1 W 61 f 61616161 0 00000000
parallel      8 2 W 21 3 ffff9999 0 00000000
parallel      8 3 W 62 f 62626262 0 00000000
parallel      9 0 R 61 0 00000000 3 61616161
parallel      9 1 R 60 0 00000000 4 60606060
parallel      9 2 R 62 0 00000000 2 62626262
parallel      9 3 R 21 0 00000000 1 12349999
parallel      9 3 R 41 0 00000000 2 12b056d0
backpressure 10 0 R 10 0 00000000 1 deadbeef
backpressure 10 0 R 21 0 00000000 2 12349999
backpressure 10 0 R 30 0 00000000 3 11cc3355
backpressure 10 0 R 41 0 00000000 4 12b056d0
backpressure 10 1 R 50 0 00000000 1 50505050
backpressure 10 1 R 61 0 00000000 2 61616161
backpressure 10 1 R 52 0 00000000 3 52525252
backpressure 10 1 R 60 0 00000000 4 60606060
backpressure 10 2 R 62 0 00000000 1 62626262
backpressure 10 2 R 21 0 00000000 2 12349999
backpressure 10 2 R 10 0 00000000 3 deadbeef
backpressure 10 3 R 41 0 00000000 1 12b056d0
backpressure 10 3 R 60 0 00000000 2 60606060
backpressure 10 3 R 61 0 00000000 3 61616161

/* vlog.f */
hw/smem_pkg.sv
hw/smem_req_dispatch.sv
hw/smem_bank.sv
hw/smem_rsp_merge.sv
hw/smem_top.sv
testbench/smem_tb.sv

/* Makefile */
# Verilator build and run for the banked scratchpad memory

VERILATOR ?= verilator
TOP       ?= smem_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
